/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lc4_processor
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' vlog.f) lc4_config.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* lc4_alu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc4_config.svh"

module lc4_alu
    import lc4_pkg::*;
(
    input  wire  [`LC4_XLEN-1:0] i_insn,
    input  wire  [`LC4_XLEN-1:0] i_pc,
    input  wire  [`LC4_XLEN-1:0] i_rs,
    input  wire  [`LC4_XLEN-1:0] i_rt,
    output logic [`LC4_XLEN-1:0] o_result
);

    logic [`LC4_XLEN-1:0] imm5;
    logic [`LC4_XLEN-1:0] imm6;
    logic [`LC4_XLEN-1:0] imm9;
    logic [`LC4_XLEN-1:0] op2;

    assign imm5 = {{(`LC4_XLEN-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(`LC4_XLEN-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(`LC4_XLEN-9){i_insn[8]}}, i_insn[8:0]};

    // bit 5 selects the immediate form of ADD and AND
    assign op2 = i_insn[5] ? imm5 : i_rt;

    always_comb begin
        case (opcode_e'(i_insn[15:12]))
            OP_BR:         o_result = i_pc + `LC4_XLEN'd1 + imm9;
            OP_ARITH:      o_result = i_rs + op2;
            OP_LOGIC:      o_result = i_rs & op2;
            OP_LDR, OP_STR: o_result = i_rs + imm6;
            OP_CONST:      o_result = imm9;
            default:       o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* lc4_assertions.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc4_config.svh"

module lc4_assertions
    import lc4_pkg::*;
(
    input wire                 gwe,
    input wire                 i_arst_n,
    input wire                 o_dmem_we,
    input wire [`LC4_XLEN-1:0] m_insn,
    input wire                 stall,
    input wb_trace_t           o_wb
);

    // a write strobe only comes from a STR opcode in M
    a_we_store: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_dmem_we |-> (m_insn[15:12] == OP_STR))
        else $error("dmem write without a store in the memory stage");

    // squashed slots retire nothing
    a_squash_quiet: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (o_wb.stall == STALL_BRANCH) |-> !o_wb.rf_we)
        else $error("squashed slot writes the register file");

    a_stall_once: assert property (@(posedge gwe) disable iff (!i_arst_n)
        stall |=> !stall)
        else $error("stall held for more than one cycle");

endmodule

bind lc4_processor lc4_assertions u_assert (
    .gwe       (gwe),
    .i_arst_n  (i_arst_n),
    .o_dmem_we (o_dmem_we),
    .m_insn    (m_stage.insn),
    .stall     (stall),
    .o_wb      (o_wb)
);

`default_nettype wire

/* lc4_config.svh */
`ifndef LC4_CONFIG_SVH
`define LC4_CONFIG_SVH

// data path and address width of the LC4 ISA
`define LC4_XLEN 16

// register select width, eight architectural registers
`define LC4_RADDR_W 3

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// stall codes as reported on the writeback trace
`define LC4_STALL_NONE 2'd0
`define LC4_STALL_BRANCH 2'd2
`define LC4_STALL_LOAD 2'd3

`endif

/* lc4_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc4_config.svh"

module lc4_decoder
    import lc4_pkg::*;
(
    input  wire  [`LC4_XLEN-1:0] i_insn,
    output ctl_t                 o_ctl
);

    opcode_e op;

    assign op = opcode_e'(i_insn[15:12]);

    always_comb begin
        o_ctl = '0;
        o_ctl.opcode = op;
        case (op)
            OP_BR: begin
                // nzp of 000 can never branch, treat it as a plain nop
                o_ctl.is_branch = |i_insn[11:9];
            end
            OP_ARITH, OP_LOGIC: begin
                // only ADD/AND and the immediate forms are kept
                if (i_insn[5] || i_insn[5:3] == 3'b000) begin
                    o_ctl.rd     = i_insn[11:9];
                    o_ctl.rs     = i_insn[8:6];
                    o_ctl.rs_re  = 1'b1;
                    o_ctl.rf_we  = 1'b1;
                    o_ctl.nzp_we = 1'b1;
                    if (!i_insn[5]) begin
                        o_ctl.rt    = i_insn[2:0];
                        o_ctl.rt_re = 1'b1;
                    end
                end
            end
            OP_LDR: begin
                o_ctl.rd      = i_insn[11:9];
                o_ctl.rs      = i_insn[8:6];
                o_ctl.rs_re   = 1'b1;
                o_ctl.rf_we   = 1'b1;
                o_ctl.nzp_we  = 1'b1;
                o_ctl.is_load = 1'b1;
            end
            OP_STR: begin
                // base in rs, store data comes through rt
                o_ctl.rt       = i_insn[11:9];
                o_ctl.rs       = i_insn[8:6];
                o_ctl.rs_re    = 1'b1;
                o_ctl.rt_re    = 1'b1;
                o_ctl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctl.rd     = i_insn[11:9];
                o_ctl.rf_we  = 1'b1;
                o_ctl.nzp_we = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* lc4_hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc4_config.svh"

module lc4_hazard_unit
    import lc4_pkg::*;
(
    input  wire ctl_t            i_d_ctl,
    input  wire ctl_t            i_x_ctl,
    input  wire ctl_t            i_m_ctl,
    input  wire ctl_t            i_w_ctl,
    input  wire  [`LC4_XLEN-1:0] i_x_rs_data,
    input  wire  [`LC4_XLEN-1:0] i_x_rt_data,
    input  wire  [`LC4_XLEN-1:0] i_m_result,
    input  wire  [`LC4_XLEN-1:0] i_m_rt_data,
    input  wire  [`LC4_XLEN-1:0] i_w_data,
    input  wire  [2:0]           i_nzp,
    output logic                 o_stall,
    output logic [`LC4_XLEN-1:0] o_x_rs,
    output logic [`LC4_XLEN-1:0] o_x_rt,
    output logic [`LC4_XLEN-1:0] o_m_store_data,
    output logic [2:0]           o_nzp
);

    logic load_use;
    logic load_branch;

    // MX first, then WX, else the value read in decode
    // a load in M still holds its address, so it is never a source here
    function automatic logic [`LC4_XLEN-1:0] fwd_x(
        input logic [`LC4_RADDR_W-1:0] sel,
        input logic                    re,
        input ctl_t                    m_ctl,
        input logic [`LC4_XLEN-1:0]    m_val,
        input ctl_t                    w_ctl,
        input logic [`LC4_XLEN-1:0]    w_val,
        input logic [`LC4_XLEN-1:0]    rf_val
    );
        if (re && m_ctl.rf_we && !m_ctl.is_load && m_ctl.rd == sel) begin
            return m_val;
        end else if (re && w_ctl.rf_we && w_ctl.rd == sel) begin
            return w_val;
        end
        return rf_val;
    endfunction

    // store data in D is not needed until M, the WM path covers it
    assign load_use = i_x_ctl.is_load &&
                      ((i_d_ctl.rs_re && i_d_ctl.rs == i_x_ctl.rd) ||
                       (i_d_ctl.rt_re && !i_d_ctl.is_store && i_d_ctl.rt == i_x_ctl.rd));

    // the loaded value sets nzp too late for a branch right behind it
    assign load_branch = i_d_ctl.is_branch && i_x_ctl.is_load;

    assign o_stall = load_use || load_branch;

    assign o_x_rs = fwd_x(i_x_ctl.rs, i_x_ctl.rs_re, i_m_ctl, i_m_result,
                          i_w_ctl, i_w_data, i_x_rs_data);
    assign o_x_rt = fwd_x(i_x_ctl.rt, i_x_ctl.rt_re, i_m_ctl, i_m_result,
                          i_w_ctl, i_w_data, i_x_rt_data);

    // WM bypass for store data
    assign o_m_store_data = (i_m_ctl.is_store && i_w_ctl.rf_we && i_w_ctl.rd == i_m_ctl.rt)
                          ? i_w_data : i_m_rt_data;

    // youngest nzp writer wins
    always_comb begin
        if (i_m_ctl.nzp_we) begin
            o_nzp = nzp_of(i_m_result);
        end else if (i_w_ctl.nzp_we) begin
            o_nzp = nzp_of(i_w_data);
        end else begin
            o_nzp = i_nzp;
        end
    end

endmodule

`default_nettype wire

/* lc4_pkg.sv */
`default_nettype none
`include "lc4_config.svh"

package lc4_pkg;

    // top four instruction bits of the kept opcodes
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_e;

    typedef enum logic [1:0] {
        STALL_NONE   = `LC4_STALL_NONE,
        STALL_BRANCH = `LC4_STALL_BRANCH,
        STALL_LOAD   = `LC4_STALL_LOAD
    } stall_e;

    // decoded control for one instruction
    typedef struct packed {
        logic [`LC4_RADDR_W-1:0] rs;
        logic [`LC4_RADDR_W-1:0] rt;
        logic [`LC4_RADDR_W-1:0] rd;
        logic                    rs_re;
        logic                    rt_re;
        logic                    rf_we;
        logic                    nzp_we;
        logic                    is_load;
        logic                    is_store;
        logic                    is_branch;
        opcode_e                 opcode;
    } ctl_t;

    // contents of one pipeline latch
    typedef struct packed {
        logic [`LC4_XLEN-1:0] pc;
        logic [`LC4_XLEN-1:0] insn;
        ctl_t                 ctl;
        stall_e               stall;
    } stage_t;

    // what the writeback stage retires this cycle
    typedef struct packed {
        stall_e                  stall;
        logic [`LC4_XLEN-1:0]    pc;
        logic [`LC4_XLEN-1:0]    insn;
        logic                    rf_we;
        logic [`LC4_RADDR_W-1:0] wsel;
        logic [`LC4_XLEN-1:0]    wdata;
        logic                    nzp_we;
        logic [2:0]              nzp;
        logic                    dmem_we;
        logic [`LC4_XLEN-1:0]    dmem_addr;
        logic [`LC4_XLEN-1:0]    dmem_data;
    } wb_trace_t;

    // condition code of a value, one-hot as {n, z, p}
    function automatic logic [2:0] nzp_of(input logic [`LC4_XLEN-1:0] value);
        if (value[`LC4_XLEN-1]) begin
            return 3'b100;
        end else if (value == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

endpackage

`default_nettype wire

/* lc4_processor.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc4_config.svh"

module lc4_processor
    import lc4_pkg::*;
(
    input  wire                  gwe,
    input  wire                  i_arst_n,
    output logic [`LC4_XLEN-1:0] o_imem_addr,
    input  wire  [`LC4_XLEN-1:0] i_imem_insn,
    output logic [`LC4_XLEN-1:0] o_dmem_addr,
    input  wire  [`LC4_XLEN-1:0] i_dmem_rdata,
    output logic                 o_dmem_we,
    output logic [`LC4_XLEN-1:0] o_dmem_wdata,
    output wb_trace_t            o_wb
);

    // empty slot carrying only a stall code
    function automatic stage_t bubble(input stall_e code);
        stage_t s;
        s = '0;
        s.stall = code;
        return s;
    endfunction

    logic [`LC4_XLEN-1:0] pc;
    logic [`LC4_XLEN-1:0] pc_next;
    stage_t               d_stage;
    stage_t               d_dec;
    stage_t               x_stage;
    stage_t               m_stage;
    stage_t               w_stage;
    ctl_t                 d_ctl;
    logic [`LC4_XLEN-1:0] rf_rs_data;
    logic [`LC4_XLEN-1:0] rf_rt_data;
    logic [`LC4_XLEN-1:0] x_rs_data;
    logic [`LC4_XLEN-1:0] x_rt_data;
    logic [`LC4_XLEN-1:0] x_rs_fwd;
    logic [`LC4_XLEN-1:0] x_rt_fwd;
    logic [`LC4_XLEN-1:0] alu_result;
    logic [`LC4_XLEN-1:0] m_result;
    logic [`LC4_XLEN-1:0] m_rt_data;
    logic [`LC4_XLEN-1:0] m_store_data;
    logic [`LC4_XLEN-1:0] w_result;
    logic [`LC4_XLEN-1:0] w_data;
    logic [2:0]           nzp_reg;
    logic [2:0]           nzp_fwd;
    logic                 stall;
    logic                 x_taken;
    logic                 m_mem;
    logic                 w_mem;

    lc4_decoder u_decoder (
        .i_insn (d_stage.insn),
        .o_ctl  (d_ctl)
    );

    // D latch with the freshly decoded control filled in
    always_comb begin
        d_dec = d_stage;
        d_dec.ctl = d_ctl;
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs      (d_ctl.rs),
        .i_rt      (d_ctl.rt),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data),
        .i_rd      (w_stage.ctl.rd),
        .i_wdata   (w_data),
        .i_we      (w_stage.ctl.rf_we)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctl        (d_ctl),
        .i_x_ctl        (x_stage.ctl),
        .i_m_ctl        (m_stage.ctl),
        .i_w_ctl        (w_stage.ctl),
        .i_x_rs_data    (x_rs_data),
        .i_x_rt_data    (x_rt_data),
        .i_m_result     (m_result),
        .i_m_rt_data    (m_rt_data),
        .i_w_data       (w_data),
        .i_nzp          (nzp_reg),
        .o_stall        (stall),
        .o_x_rs         (x_rs_fwd),
        .o_x_rt         (x_rt_fwd),
        .o_m_store_data (m_store_data),
        .o_nzp          (nzp_fwd)
    );

    lc4_alu u_alu (
        .i_insn   (x_stage.insn),
        .i_pc     (x_stage.pc),
        .i_rs     (x_rs_fwd),
        .i_rt     (x_rt_fwd),
        .o_result (alu_result)
    );

    // branch condition bits against the forwarded nzp
    assign x_taken = x_stage.ctl.is_branch && |(x_stage.insn[11:9] & nzp_fwd);

    assign pc_next = x_taken ? alu_result :
                     stall   ? pc :
                               pc + `LC4_XLEN'd1;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= `LC4_RESET_PC;
            d_stage <= bubble(STALL_BRANCH);
            x_stage <= bubble(STALL_BRANCH);
            m_stage <= bubble(STALL_BRANCH);
            w_stage <= bubble(STALL_BRANCH);
            nzp_reg <= '0;
        end else begin
            pc      <= pc_next;
            m_stage <= x_stage;
            w_stage <= m_stage;
            if (x_taken) begin
                // squash the two younger slots in F and D
                d_stage <= bubble(STALL_BRANCH);
                x_stage <= bubble(STALL_BRANCH);
            end else if (stall) begin
                x_stage <= bubble(STALL_LOAD);
            end else begin
                d_stage <= '{pc: pc, insn: i_imem_insn, ctl: '0, stall: STALL_NONE};
                x_stage <= d_dec;
            end
            if (w_stage.ctl.nzp_we) begin
                nzp_reg <= nzp_of(w_data);
            end
        end
    end

    // datapath registers, qualified by the ctl that travels with them
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_rs_data <= '0;
            x_rt_data <= '0;
            m_result  <= '0;
            m_rt_data <= '0;
            w_result  <= '0;
            w_data    <= '0;
        end else begin
            x_rs_data <= rf_rs_data;
            x_rt_data <= rf_rt_data;
            m_result  <= alu_result;
            m_rt_data <= x_rt_fwd;
            w_result  <= m_result;
            if (m_stage.ctl.is_load) begin
                w_data <= i_dmem_rdata;
            end else if (m_stage.ctl.is_store) begin
                w_data <= m_store_data;
            end else begin
                w_data <= m_result;
            end
        end
    end

    assign o_imem_addr = pc;

    assign m_mem        = m_stage.ctl.is_load || m_stage.ctl.is_store;
    assign o_dmem_addr  = m_mem ? m_result : '0;
    assign o_dmem_we    = m_stage.ctl.is_store;
    assign o_dmem_wdata = m_stage.ctl.is_store ? m_store_data : '0;

    // writeback trace
    assign w_mem = w_stage.ctl.is_load || w_stage.ctl.is_store;

    always_comb begin
        o_wb.stall     = w_stage.stall;
        o_wb.pc        = w_stage.pc;
        o_wb.insn      = w_stage.insn;
        o_wb.rf_we     = w_stage.ctl.rf_we;
        o_wb.wsel      = w_stage.ctl.rd;
        o_wb.wdata     = w_stage.ctl.rf_we ? w_data : '0;
        o_wb.nzp_we    = w_stage.ctl.nzp_we;
        o_wb.nzp       = w_stage.ctl.nzp_we ? nzp_of(w_data) : 3'b000;
        o_wb.dmem_we   = w_stage.ctl.is_store;
        o_wb.dmem_addr = w_mem ? w_result : '0;
        o_wb.dmem_data = w_mem ? w_data : '0;
    end

endmodule

`default_nettype wire

/* lc4_regfile.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc4_config.svh"

module lc4_regfile (
    input  wire                     gwe,
    input  wire                     i_arst_n,
    input  wire  [`LC4_RADDR_W-1:0] i_rs,
    input  wire  [`LC4_RADDR_W-1:0] i_rt,
    output logic [`LC4_XLEN-1:0]    o_rs_data,
    output logic [`LC4_XLEN-1:0]    o_rt_data,
    input  wire  [`LC4_RADDR_W-1:0] i_rd,
    input  wire  [`LC4_XLEN-1:0]    i_wdata,
    input  wire                     i_we
);

    localparam int NREGS = 1 << `LC4_RADDR_W;

    logic [`LC4_XLEN-1:0] regs [NREGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // a write in the same cycle shows up on the read ports right away
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

/* tb_lc4_processor.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc4_config.svh"

module tb_lc4_processor
    import lc4_pkg::*;
();

    // one expected writeback slot
    typedef struct packed {
        stall_e      stall;
        logic [15:0] pc;
        logic        rf_we;
        logic [2:0]  wsel;
        logic [15:0] wdata;
        logic [2:0]  nzp;
        logic        dmem_we;
        logic [15:0] addr;
        logic [15:0] data;
    } exp_t;

    logic        gwe;
    logic        i_arst_n;
    logic [15:0] o_imem_addr;
    logic [15:0] i_imem_insn;
    logic [15:0] o_dmem_addr;
    logic [15:0] i_dmem_rdata;
    logic        o_dmem_we;
    logic [15:0] o_dmem_wdata;
    wb_trace_t   o_wb;

    logic [15:0] imem [64];
    logic [15:0] dmem [256];
    logic [15:0] ref_mem [256];
    logic [15:0] iofs;
    exp_t        exp_q [$];
    integer      seed = 32'h0381_e3aa;
    int          errors = 0;
    int          checks = 0;

    lc4_processor u_dut (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_insn  (i_imem_insn),
        .o_dmem_addr  (o_dmem_addr),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .o_wb         (o_wb)
    );

    initial begin
        gwe = 1'b0;
        forever #10 gwe = ~gwe;
    end

    // memories answer in the same cycle
    assign iofs = o_imem_addr - `LC4_RESET_PC;
    assign i_imem_insn = (iofs < 16'd64) ? imem[iofs[5:0]] : 16'h0000;
    assign i_dmem_rdata = dmem[o_dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr[7:0]] <= o_dmem_wdata;
        end
    end

    // n, z, p of a 16-bit value
    function automatic logic [2:0] sign_code(input logic [15:0] v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    task automatic check_stall(input string name, input stall_e exp, input stall_e act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_nzp(input string name, input logic [2:0] exp, input logic [2:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic add_slot(input stall_e s, input logic [15:0] pc, input logic we,
                            input logic [2:0] rd, input logic [15:0] wd,
                            input logic dwe, input logic [15:0] a, input logic [15:0] d);
        exp_t e;
        e = '{s, pc, we, rd, wd, (we ? sign_code(wd) : 3'b000), dwe, a, d};
        exp_q.push_back(e);
    endtask

    task automatic add_alu(input logic [15:0] pc, input logic [2:0] rd, input logic [15:0] v);
        add_slot(STALL_NONE, pc, 1'b1, rd, v, 1'b0, 16'h0, 16'h0);
    endtask

    task automatic add_load(input logic [15:0] pc, input logic [2:0] rd,
                            input logic [15:0] a, input logic [15:0] v);
        add_slot(STALL_NONE, pc, 1'b1, rd, v, 1'b0, a, v);
    endtask

    task automatic add_quiet(input stall_e s, input logic [15:0] pc);
        add_slot(s, pc, 1'b0, 3'd0, 16'h0, 1'b0, 16'h0, 16'h0);
    endtask

    // program at the reset PC, then the writeback slots it must produce
    task automatic build_tables();
        logic [15:0] prog [22];
        prog = '{16'h9205, 16'h95FD, 16'h1642, 16'h18FE, 16'h5A81, 16'h5CA7,
                 16'h9E10, 16'h13A3, 16'h73C2, 16'h65C2, 16'h1681, 16'h0803,
                 16'h69C2, 16'h0202, 16'h9201, 16'h9202, 16'h6BC5, 16'h91FF,
                 16'h0000, 16'h6DC5, 16'h7DC3, 16'h67C3};
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < 22) ? prog[i] : 16'h0000;
        end
        add_alu(16'h8200, 3'd1, 16'h0005);
        add_alu(16'h8201, 3'd2, 16'hFFFD);
        add_alu(16'h8202, 3'd3, 16'h0002);
        add_alu(16'h8203, 3'd4, 16'h0000);
        add_alu(16'h8204, 3'd5, 16'h0005);
        add_alu(16'h8205, 3'd6, 16'h0005);
        add_alu(16'h8206, 3'd7, 16'h0010);
        add_alu(16'h8207, 3'd1, 16'h0008);
        // store data 8 comes from the ADDI right before it
        add_slot(STALL_NONE, 16'h8208, 1'b0, 3'd0, 16'h0, 1'b1, 16'h0012, 16'h0008);
        add_load(16'h8209, 3'd2, 16'h0012, 16'h0008);
        add_quiet(STALL_LOAD, 16'h0);
        add_alu(16'h820A, 3'd3, 16'h0010);
        // BRn not taken
        add_quiet(STALL_NONE, 16'h820B);
        add_load(16'h820C, 3'd4, 16'h0012, 16'h0008);
        add_quiet(STALL_LOAD, 16'h0);
        add_quiet(STALL_NONE, 16'h820D);
        add_quiet(STALL_BRANCH, 16'h0);
        add_quiet(STALL_BRANCH, 16'h0);
        add_load(16'h8210, 3'd5, 16'h0015, ref_mem[8'h15]);
        add_alu(16'h8211, 3'd0, 16'hFFFF);
        add_quiet(STALL_NONE, 16'h8212);
        add_load(16'h8213, 3'd6, 16'h0015, ref_mem[8'h15]);
        // store data is the value loaded right before it, forwarded from W to M
        add_slot(STALL_NONE, 16'h8214, 1'b0, 3'd0, 16'h0, 1'b1, 16'h0013, ref_mem[8'h15]);
        add_load(16'h8215, 3'd3, 16'h0013, ref_mem[8'h15]);
    endtask

    initial begin
        exp_t        e;
        string       name;
        int          waited;
        logic [31:0] rnd;
        logic [15:0] ofs;
        i_arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rnd = $random(seed);
            ref_mem[i] = rnd[15:0];
            dmem[i] <= rnd[15:0];
        end
        build_tables();
        repeat (2) @(posedge gwe);
        @(negedge gwe);
        i_arst_n = 1'b1;
        check_word("reset pc", `LC4_RESET_PC, o_imem_addr);
        check_stall("reset stall", STALL_BRANCH, o_wb.stall);
        check_flag("reset rf_we", 1'b0, o_wb.rf_we);
        // skip the empty slots left by reset
        waited = 0;
        while (o_wb.stall == STALL_BRANCH && o_wb.pc == 16'h0 && waited < 20) begin
            @(negedge gwe);
            waited++;
        end
        if (waited >= 20) begin
            errors++;
            $display("no instruction reached writeback after reset");
        end
        for (int k = 0; k < exp_q.size(); k++) begin
            if (k > 0) begin
                @(negedge gwe);
            end
            e = exp_q[k];
            name = $sformatf("slot%0d", k);
            ofs = e.pc - `LC4_RESET_PC;
            check_stall({name, " stall"}, e.stall, o_wb.stall);
            check_word({name, " pc"}, e.pc, o_wb.pc);
            check_word({name, " insn"},
                       (e.stall == STALL_NONE) ? imem[ofs[5:0]] : 16'h0000, o_wb.insn);
            check_flag({name, " rf_we"}, e.rf_we, o_wb.rf_we);
            if (e.rf_we) begin
                check_word({name, " wsel"}, {13'd0, e.wsel}, {13'd0, o_wb.wsel});
            end
            check_word({name, " wdata"}, e.wdata, o_wb.wdata);
            // every register writer of the kept subset also sets nzp
            check_flag({name, " nzp_we"}, e.rf_we, o_wb.nzp_we);
            check_nzp({name, " nzp"}, e.nzp, o_wb.nzp);
            check_flag({name, " dmem_we"}, e.dmem_we, o_wb.dmem_we);
            check_word({name, " dmem_addr"}, e.addr, o_wb.dmem_addr);
            check_word({name, " dmem_data"}, e.data, o_wb.dmem_data);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(20 * 500);
        $display("simulation timed out before the trace was complete");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
lc4_pkg.sv
lc4_decoder.sv
lc4_alu.sv
lc4_regfile.sv
lc4_hazard_unit.sv
lc4_processor.sv
lc4_assertions.sv
tb_lc4_processor.sv
